// ==== frame_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_sync (
	input wire o_clk,
	input wire o_resetn,
	input wire i_fsync,
	output logic o_update_pulse,
	output logic o_fsync,
	output logic o_out_ce
);

	logic fsync_d1;
	logic fsync_d2;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			fsync_d1 <= 1'b0;
			fsync_d2 <= 1'b0;
			o_update_pulse <= 1'b0;
			o_fsync <= 1'b0;
			o_out_ce <= 1'b0;
		end else begin
			fsync_d1 <= i_fsync;
			fsync_d2 <= fsync_d1;
			// rising edge of the sampled sync
			o_update_pulse <= fsync_d1 & ~fsync_d2;
			// lines up with the live config change
			o_fsync <= o_update_pulse;
			// sticky from the first frame on
			if (o_update_pulse)
				o_out_ce <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== fsctl_defines.svh ====
`ifndef FSCTL_DEFINES_SVH
`define FSCTL_DEFINES_SVH

// block counts
`define FSCTL_STREAM_NBR 2
`define FSCTL_MOTOR_NBR 2

// fixed output frame size
`define FSCTL_IMG_WDEF 320
`define FSCTL_IMG_HDEF 240

`define FSCTL_CORE_VERSION 32'h0102_0000

// ------------------------------
// register map
// ------------------------------
`define FSCTL_REG_SINT_EN 8'd0
`define FSCTL_REG_SINT_ST 8'd1
`define FSCTL_REG_SBUF_IDX 8'd2
`define FSCTL_REG_CFG_HOLD 8'd3

// six words per stream starting at base + stride * s
`define FSCTL_REG_STREAM_BASE 8
`define FSCTL_REG_STREAM_STRIDE 8

`define FSCTL_REG_MEN 8'd32
`define FSCTL_REG_MINT_EN 8'd33
`define FSCTL_REG_MINT_ST 8'd34
`define FSCTL_REG_MSTATE 8'd35
`define FSCTL_REG_MSTART 8'd36
`define FSCTL_REG_MDIR 8'd38
// first motor, one word per motor after it
`define FSCTL_REG_MSTEP 8'd47
`define FSCTL_REG_MSPEED 8'd55

`define FSCTL_REG_VERSION 8'd255

`endif

// ==== fsctl_golden.txt ====
# op args, hex: W addr data | R addr expected | F | D stream | S motor level
# C port expected | T test name printed when the test ends
C fsync 0
C out_ce 0
C intr 0
C motors 0
R ff 01020000
C out_w 140
C out_h f0
T reset
W 08 014000f0
W 09 00100020
W 0a 00a00078
W 0b 00050006
W 0c 00400030
W 0d 00000003
W 10 00800060
C live00 0
C live05 0
R 08 014000f0
F
C live00 014000f0
C live01 00100020
C live02 00a00078
C live03 00050006
C live04 00400030
C live05 00000003
C live10 00800060
C out_ce 1
W 03 1
R 03 1
W 08 01230456
F
C live00 014000f0
W 03 0
F
C live00 01230456
T stream_cfg
W 00 1
D 0
C intr 1
R 01 1
W 01 1
C intr 0
C rd_en0 1
R 02 21
D 1
C intr 0
R 01 2
W 01 2
C rd_en1 1
R 01 0
T stream_irq
W 20 00000011
C m0_xen 1
C m1_xen 1
C m0_xrst 0
W 26 2
C m0_dir 0
C m1_dir 1
W 2f 1234
W 37 abcd
W 30 0042
C m0_step 1234
C m0_speed abcd
R 2f 1234
R 37 abcd
R 30 42
W 24 00000021
C m0_start 1
C m1_stop 1
C m0_stop 0
C m1_start 0
T motor_ctl
W 21 1
S 0 1
S 0 0
C intr 1
R 22 1
W 22 1
C intr 0
W 21 0
S 0 1
S 0 0
C intr 0
R 22 1
W 22 1
R 23 0
T motor_irq

// ==== fsctl_pkg.sv ====
`default_nettype none

`include "fsctl_defines.svh"

package fsctl_pkg;

	typedef logic [7:0] reg_addr_t;
	typedef logic [31:0] reg_data_t;

	// pixel columns and rows
	typedef logic [11:0] img_w_t;
	typedef logic [11:0] img_h_t;

	typedef logic [1:0] buf_idx_t;
	typedef logic [15:0] step_t;
	typedef logic [15:0] speed_t;

	// one registered host write
	typedef struct packed {
		logic en;
		reg_addr_t addr;
		reg_data_t data;
	} reg_wr_t;

	typedef struct packed {
		img_w_t width;
		img_h_t height;
		img_w_t win_left;
		img_h_t win_top;
		img_w_t win_width;
		img_h_t win_height;
		img_w_t dst_left;
		img_h_t dst_top;
		img_w_t dst_width;
		img_h_t dst_height;
		logic [`FSCTL_STREAM_NBR-1:0] dst_bmp;
	} stream_cfg_t;

	typedef struct packed {
		logic xen;
		logic xrst;
		logic start;
		logic stop;
		logic dir;
		speed_t speed;
		step_t step;
	} motor_cmd_t;

endpackage

`default_nettype wire

// ==== fsctl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsctl_defines.svh"

module fsctl_top (
	input wire o_clk,
	input wire o_resetn,
	// host
	input wire i_wr_en,
	input wire fsctl_pkg::reg_addr_t i_wr_addr,
	input wire fsctl_pkg::reg_data_t i_wr_data,
	input wire i_rd_en,
	input wire fsctl_pkg::reg_addr_t i_rd_addr,
	output fsctl_pkg::reg_data_t o_rd_data,
	// frame
	input wire i_fsync,
	output logic o_fsync,
	output logic o_out_ce,
	output logic o_intr,
	output fsctl_pkg::img_w_t o_out_width,
	output fsctl_pkg::img_h_t o_out_height,
	// streams
	output fsctl_pkg::stream_cfg_t [`FSCTL_STREAM_NBR-1:0] o_stream_cfg,
	input wire [`FSCTL_STREAM_NBR-1:0] i_s_wr_done,
	output logic [`FSCTL_STREAM_NBR-1:0] o_s_rd_en,
	input wire fsctl_pkg::buf_idx_t [`FSCTL_STREAM_NBR-1:0] i_s_rd_buf_idx,
	// motors
	output fsctl_pkg::motor_cmd_t [`FSCTL_MOTOR_NBR-1:0] o_motor,
	input wire [`FSCTL_MOTOR_NBR-1:0] i_motor_state
);

	fsctl_pkg::reg_wr_t wr_bus;
	fsctl_pkg::reg_addr_t rd_addr;
	fsctl_pkg::reg_data_t stream_rd;
	fsctl_pkg::reg_data_t motor_rd;
	logic update_pulse;
	logic cfg_update;
	logic stream_irq;
	logic motor_irq;

	assign o_out_width = fsctl_pkg::img_w_t'(`FSCTL_IMG_WDEF);
	assign o_out_height = fsctl_pkg::img_h_t'(`FSCTL_IMG_HDEF);

	reg_host_port i_reg_host_port (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_wr_en(i_wr_en), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
		.i_rd_en(i_rd_en), .i_rd_addr(i_rd_addr),
		.i_sync_pulse(update_pulse),
		.i_stream_rd(stream_rd), .i_motor_rd(motor_rd),
		.i_stream_irq(stream_irq), .i_motor_irq(motor_irq),
		.o_wr(wr_bus), .o_rd_addr(rd_addr), .o_rd_data(o_rd_data),
		.o_cfg_update(cfg_update), .o_intr(o_intr)
	);

	frame_sync i_frame_sync (
		.o_clk(o_clk), .o_resetn(o_resetn), .i_fsync(i_fsync),
		.o_update_pulse(update_pulse), .o_fsync(o_fsync), .o_out_ce(o_out_ce)
	);

	stream_cfg i_stream_cfg (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_wr(wr_bus), .i_rd_addr(rd_addr), .i_cfg_update(cfg_update),
		.i_s_wr_done(i_s_wr_done), .i_s_rd_buf_idx(i_s_rd_buf_idx),
		.o_cfg(o_stream_cfg), .o_s_rd_en(o_s_rd_en),
		.o_rd_data(stream_rd), .o_irq(stream_irq)
	);

	motor_ctl i_motor_ctl (
		.o_clk(o_clk), .o_resetn(o_resetn),
		.i_wr(wr_bus), .i_rd_addr(rd_addr), .i_motor_state(i_motor_state),
		.o_motor(o_motor), .o_rd_data(motor_rd), .o_irq(motor_irq)
	);

endmodule

`default_nettype wire

// ==== motor_ctl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsctl_defines.svh"

module motor_ctl (
	input wire o_clk,
	input wire o_resetn,
	input wire fsctl_pkg::reg_wr_t i_wr,
	input wire fsctl_pkg::reg_addr_t i_rd_addr,
	input wire [`FSCTL_MOTOR_NBR-1:0] i_motor_state,
	output fsctl_pkg::motor_cmd_t [`FSCTL_MOTOR_NBR-1:0] o_motor,
	output fsctl_pkg::reg_data_t o_rd_data,
	output logic o_irq
);

	logic [`FSCTL_MOTOR_NBR-1:0] state_q;
	logic [`FSCTL_MOTOR_NBR-1:0] state_qq;
	logic [`FSCTL_MOTOR_NBR-1:0] mint_en;
	logic [`FSCTL_MOTOR_NBR-1:0] mint_st;
	logic [`FSCTL_MOTOR_NBR-1:0] st_clr;

	for (genvar m = 0; m < `FSCTL_MOTOR_NBR; m++) begin : g_motor
		fsctl_pkg::motor_cmd_t cmd;

		always_ff @(posedge o_clk) begin
			if (!o_resetn) begin
				cmd <= '0;
			end else begin
				cmd.start <= 1'b0;
				cmd.stop <= 1'b0;
				if (i_wr.en) begin
					case (i_wr.addr)
						`FSCTL_REG_MEN: begin
							cmd.xen <= i_wr.data[4 * m];
							cmd.xrst <= i_wr.data[4 * m + 1];
						end
						// stop has priority
						`FSCTL_REG_MSTART: begin
							cmd.start <= i_wr.data[4 * m] & ~i_wr.data[4 * m + 1];
							cmd.stop <= i_wr.data[4 * m + 1];
						end
						`FSCTL_REG_MDIR: cmd.dir <= i_wr.data[m];
						fsctl_pkg::reg_addr_t'(`FSCTL_REG_MSTEP + m):
							cmd.step <= i_wr.data[15:0];
						fsctl_pkg::reg_addr_t'(`FSCTL_REG_MSPEED + m):
							cmd.speed <= i_wr.data[15:0];
						default: ;
					endcase
				end
			end
		end

		assign o_motor[m] = cmd;

		// single-cycle pulses, never both at once
		a_start_stop_excl: assert property (@(posedge o_clk) disable iff (!o_resetn)
			o_motor[m].start |-> !o_motor[m].stop ##1 !o_motor[m].start);

		a_stop_single: assert property (@(posedge o_clk) disable iff (!o_resetn)
			o_motor[m].stop |=> !o_motor[m].stop);
	end

	// ------------------------------
	// motor finished interrupts
	// ------------------------------
	assign st_clr = (i_wr.en && i_wr.addr == `FSCTL_REG_MINT_ST) ?
		i_wr.data[`FSCTL_MOTOR_NBR-1:0] : '0;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			state_q <= '0;
			state_qq <= '0;
			mint_en <= '0;
			mint_st <= '0;
		end else begin
			state_q <= i_motor_state;
			state_qq <= state_q;
			if (i_wr.en && i_wr.addr == `FSCTL_REG_MINT_EN)
				mint_en <= i_wr.data[`FSCTL_MOTOR_NBR-1:0];
			// busy to idle marks the move done
			mint_st <= (mint_st & ~st_clr) | (state_qq & ~state_q);
		end
	end

	assign o_irq = |(mint_en & mint_st);

	always_comb begin
		o_rd_data = '0;
		case (i_rd_addr)
			`FSCTL_REG_MEN: begin
				for (int m = 0; m < `FSCTL_MOTOR_NBR; m++) begin
					o_rd_data[4 * m] = o_motor[m].xen;
					o_rd_data[4 * m + 1] = o_motor[m].xrst;
				end
			end
			`FSCTL_REG_MINT_EN: o_rd_data = fsctl_pkg::reg_data_t'(mint_en);
			`FSCTL_REG_MINT_ST: o_rd_data = fsctl_pkg::reg_data_t'(mint_st);
			`FSCTL_REG_MSTATE: o_rd_data = fsctl_pkg::reg_data_t'(state_q);
			`FSCTL_REG_MDIR: begin
				for (int m = 0; m < `FSCTL_MOTOR_NBR; m++)
					o_rd_data[m] = o_motor[m].dir;
			end
			default: begin
				for (int m = 0; m < `FSCTL_MOTOR_NBR; m++) begin
					if (i_rd_addr == fsctl_pkg::reg_addr_t'(`FSCTL_REG_MSTEP + m))
						o_rd_data = {16'd0, o_motor[m].step};
					if (i_rd_addr == fsctl_pkg::reg_addr_t'(`FSCTL_REG_MSPEED + m))
						o_rd_data = {16'd0, o_motor[m].speed};
				end
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== reg_host_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsctl_defines.svh"

module reg_host_port (
	input wire o_clk,
	input wire o_resetn,
	input wire i_wr_en,
	input wire fsctl_pkg::reg_addr_t i_wr_addr,
	input wire fsctl_pkg::reg_data_t i_wr_data,
	input wire i_rd_en,
	input wire fsctl_pkg::reg_addr_t i_rd_addr,
	input wire i_sync_pulse,
	input wire fsctl_pkg::reg_data_t i_stream_rd,
	input wire fsctl_pkg::reg_data_t i_motor_rd,
	input wire i_stream_irq,
	input wire i_motor_irq,
	output fsctl_pkg::reg_wr_t o_wr,
	output fsctl_pkg::reg_addr_t o_rd_addr,
	output fsctl_pkg::reg_data_t o_rd_data,
	output logic o_cfg_update,
	output logic o_intr
);

	logic rd_en_q;
	logic cfg_hold;
	fsctl_pkg::reg_data_t rd_word;

	// host strobes, one cycle in
	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			o_wr.en <= 1'b0;
			rd_en_q <= 1'b0;
		end else begin
			o_wr.en <= i_wr_en;
			rd_en_q <= i_rd_en;
		end
		o_wr.addr <= i_wr_addr;
		o_wr.data <= i_wr_data;
		o_rd_addr <= i_rd_addr;
	end

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			cfg_hold <= 1'b0;
		end else if (o_wr.en && o_wr.addr == `FSCTL_REG_CFG_HOLD) begin
			cfg_hold <= o_wr.data[0];
		end
	end

	// held config skips this frame
	assign o_cfg_update = i_sync_pulse & ~cfg_hold;

	// ------------------------------
	// read select
	// ------------------------------
	always_comb begin
		if (o_rd_addr == `FSCTL_REG_VERSION)
			rd_word = `FSCTL_CORE_VERSION;
		else if (o_rd_addr == `FSCTL_REG_CFG_HOLD)
			rd_word = fsctl_pkg::reg_data_t'(cfg_hold);
		else if (o_rd_addr >= `FSCTL_REG_MEN)
			rd_word = i_motor_rd;
		else
			rd_word = i_stream_rd;
	end

	// holds until the next read
	always_ff @(posedge o_clk) begin
		if (rd_en_q)
			o_rd_data <= rd_word;
	end

	assign o_intr = i_stream_irq | i_motor_irq;

	// one update per frame, never with hold set
	a_hold_blocks_update: assert property (@(posedge o_clk) disable iff (!o_resetn)
		o_cfg_update |-> !cfg_hold ##1 !o_cfg_update);

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
fsctl_pkg.sv
reg_host_port.sv
frame_sync.sv
stream_cfg.sv
motor_ctl.sv
fsctl_top.sv
tb_clk_gen.sv
tb_fsctl.sv

// ==== stream_cfg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsctl_defines.svh"

module stream_cfg (
	input wire o_clk,
	input wire o_resetn,
	input wire fsctl_pkg::reg_wr_t i_wr,
	input wire fsctl_pkg::reg_addr_t i_rd_addr,
	input wire i_cfg_update,
	input wire [`FSCTL_STREAM_NBR-1:0] i_s_wr_done,
	input wire fsctl_pkg::buf_idx_t [`FSCTL_STREAM_NBR-1:0] i_s_rd_buf_idx,
	output fsctl_pkg::stream_cfg_t [`FSCTL_STREAM_NBR-1:0] o_cfg,
	output logic [`FSCTL_STREAM_NBR-1:0] o_s_rd_en,
	output fsctl_pkg::reg_data_t o_rd_data,
	output logic o_irq
);

	logic [`FSCTL_STREAM_NBR-1:0] done_q;
	logic [`FSCTL_STREAM_NBR-1:0] done_qq;
	logic [`FSCTL_STREAM_NBR-1:0] done_rise;
	logic [`FSCTL_STREAM_NBR-1:0] sint_en;
	logic [`FSCTL_STREAM_NBR-1:0] sint_st;
	logic [`FSCTL_STREAM_NBR-1:0] st_clr;
	fsctl_pkg::reg_data_t [`FSCTL_STREAM_NBR-1:0] stream_rd;

	// register word at offset off of one stream
	function automatic fsctl_pkg::reg_data_t cfg_word(input fsctl_pkg::stream_cfg_t c,
		input logic [2:0] off);
		fsctl_pkg::reg_data_t w;
		w = '0;
		case (off)
			3'd0: w = {4'd0, c.width, 4'd0, c.height};
			3'd1: w = {4'd0, c.win_left, 4'd0, c.win_top};
			3'd2: w = {4'd0, c.win_width, 4'd0, c.win_height};
			3'd3: w = {4'd0, c.dst_left, 4'd0, c.dst_top};
			3'd4: w = {4'd0, c.dst_width, 4'd0, c.dst_height};
			3'd5: w[`FSCTL_STREAM_NBR-1:0] = c.dst_bmp;
			default: w = '0;
		endcase
		return w;
	endfunction

	// ------------------------------
	// per-stream configuration
	// ------------------------------
	for (genvar s = 0; s < `FSCTL_STREAM_NBR; s++) begin : g_stream
		localparam int BASE = `FSCTL_REG_STREAM_BASE + s * `FSCTL_REG_STREAM_STRIDE;

		fsctl_pkg::stream_cfg_t pend;
		fsctl_pkg::stream_cfg_t live;
		fsctl_pkg::reg_addr_t wr_off;
		fsctl_pkg::reg_addr_t rd_off;

		// below the base wraps to a large offset
		assign wr_off = i_wr.addr - fsctl_pkg::reg_addr_t'(BASE);
		assign rd_off = i_rd_addr - fsctl_pkg::reg_addr_t'(BASE);

		always_ff @(posedge o_clk) begin
			if (!o_resetn) begin
				pend <= '0;
				live <= '0;
			end else begin
				if (i_wr.en) begin
					case (wr_off)
						8'd0: begin
							pend.height <= i_wr.data[11:0];
							pend.width <= i_wr.data[27:16];
						end
						8'd1: begin
							pend.win_top <= i_wr.data[11:0];
							pend.win_left <= i_wr.data[27:16];
						end
						8'd2: begin
							pend.win_height <= i_wr.data[11:0];
							pend.win_width <= i_wr.data[27:16];
						end
						8'd3: begin
							pend.dst_top <= i_wr.data[11:0];
							pend.dst_left <= i_wr.data[27:16];
						end
						8'd4: begin
							pend.dst_height <= i_wr.data[11:0];
							pend.dst_width <= i_wr.data[27:16];
						end
						8'd5: pend.dst_bmp <= i_wr.data[`FSCTL_STREAM_NBR-1:0];
						default: ;
					endcase
				end
				if (i_cfg_update)
					live <= pend;
			end
		end

		assign o_cfg[s] = live;
		assign stream_rd[s] = (rd_off < 8'd6) ? cfg_word(pend, rd_off[2:0]) : '0;

		a_rd_en_single: assert property (@(posedge o_clk) disable iff (!o_resetn)
			o_s_rd_en[s] |=> !o_s_rd_en[s]);
	end

	// ------------------------------
	// write-done interrupts
	// ------------------------------
	assign done_rise = done_q & ~done_qq;
	assign st_clr = (i_wr.en && i_wr.addr == `FSCTL_REG_SINT_ST) ?
		i_wr.data[`FSCTL_STREAM_NBR-1:0] : '0;

	always_ff @(posedge o_clk) begin
		if (!o_resetn) begin
			done_q <= '0;
			done_qq <= '0;
			sint_en <= '0;
			sint_st <= '0;
			o_s_rd_en <= '0;
		end else begin
			done_q <= i_s_wr_done;
			done_qq <= done_q;
			if (i_wr.en && i_wr.addr == `FSCTL_REG_SINT_EN)
				sint_en <= i_wr.data[`FSCTL_STREAM_NBR-1:0];
			// a new frame wins over a clear in the same cycle
			sint_st <= (sint_st & ~st_clr) | done_rise;
			o_s_rd_en <= st_clr;
		end
	end

	assign o_irq = |(sint_en & sint_st);

	always_comb begin
		o_rd_data = '0;
		for (int s = 0; s < `FSCTL_STREAM_NBR; s++)
			o_rd_data = o_rd_data | stream_rd[s];
		case (i_rd_addr)
			`FSCTL_REG_SINT_EN: o_rd_data = fsctl_pkg::reg_data_t'(sint_en);
			`FSCTL_REG_SINT_ST: o_rd_data = fsctl_pkg::reg_data_t'(sint_st);
			`FSCTL_REG_SBUF_IDX: begin
				for (int s = 0; s < `FSCTL_STREAM_NBR; s++)
					o_rd_data[4 * s +: 2] = i_s_rd_buf_idx[s];
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
	parameter real PERIOD = 8.0,
	parameter int RESET_CYCLES = 2
) (
	output logic o_clk,
	output logic o_resetn
);

	initial begin
		o_clk = 1'b0;
		forever #(PERIOD / 2.0) o_clk = ~o_clk;
	end

	// reset released on a rising edge
	initial begin
		o_resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_resetn <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb_fsctl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fsctl_defines.svh"

module tb_fsctl;

	logic clk;
	logic resetn;
	logic wr_en;
	fsctl_pkg::reg_addr_t wr_addr;
	fsctl_pkg::reg_data_t wr_data;
	logic rd_en;
	fsctl_pkg::reg_addr_t rd_addr;
	fsctl_pkg::reg_data_t rd_data;
	logic fsync_in;
	logic fsync_out;
	logic out_ce;
	logic intr;
	fsctl_pkg::img_w_t out_width;
	fsctl_pkg::img_h_t out_height;
	fsctl_pkg::stream_cfg_t [`FSCTL_STREAM_NBR-1:0] stream_cfg;
	logic [`FSCTL_STREAM_NBR-1:0] wr_done;
	logic [`FSCTL_STREAM_NBR-1:0] s_rd_en;
	fsctl_pkg::buf_idx_t [`FSCTL_STREAM_NBR-1:0] buf_idx;
	fsctl_pkg::motor_cmd_t [`FSCTL_MOTOR_NBR-1:0] motor_out;
	logic [`FSCTL_MOTOR_NBR-1:0] motor_state;

	int checks = 0;
	int errors = 0;
	int tests = 0;
	int test_checks = 0;
	int test_errors = 0;
	int cycles = 0;
	int limit = 0;
	int frames = 0;
	// high cycles seen on each pulse output
	int rd_en_cnt [`FSCTL_STREAM_NBR];
	int start_cnt [`FSCTL_MOTOR_NBR];
	int stop_cnt [`FSCTL_MOTOR_NBR];

	tb_clk_gen #(.PERIOD(8.0), .RESET_CYCLES(2)) i_tb_clk_gen (
		.o_clk(clk), .o_resetn(resetn)
	);

	fsctl_top i_fsctl_top (
		.o_clk(clk), .o_resetn(resetn),
		.i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_data(wr_data),
		.i_rd_en(rd_en), .i_rd_addr(rd_addr), .o_rd_data(rd_data),
		.i_fsync(fsync_in), .o_fsync(fsync_out), .o_out_ce(out_ce), .o_intr(intr),
		.o_out_width(out_width), .o_out_height(out_height),
		.o_stream_cfg(stream_cfg), .i_s_wr_done(wr_done), .o_s_rd_en(s_rd_en),
		.i_s_rd_buf_idx(buf_idx),
		.o_motor(motor_out), .i_motor_state(motor_state)
	);

	always @(negedge clk) begin
		if (resetn) begin
			for (int s = 0; s < `FSCTL_STREAM_NBR; s++)
				if (s_rd_en[s] === 1'b1)
					rd_en_cnt[s]++;
			for (int m = 0; m < `FSCTL_MOTOR_NBR; m++) begin
				if (motor_out[m].start === 1'b1)
					start_cnt[m]++;
				if (motor_out[m].stop === 1'b1)
					stop_cnt[m]++;
			end
		end
	end

	// ------------------------------
	// watchdog
	// ------------------------------
	initial begin
		wait (limit != 0);
		while (cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("run did not finish within %0d cycles", limit);
		$display("TB FAILED");
		$finish;
	end

	task automatic check_value(input string sig, input logic [31:0] exp,
		input logic [31:0] act);
		checks++;
		test_checks++;
		if (act !== exp) begin
			errors++;
			test_errors++;
			$display("** Error at %0d ns: %s expected %h actual %h", $time, sig, exp, act);
		end
	endtask

	// stream word laid out as in the register map
	function automatic logic [31:0] live_word(input int s, input int off);
		fsctl_pkg::stream_cfg_t c;
		logic [31:0] w;
		c = stream_cfg[s];
		w = '0;
		case (off)
			0: w = {4'd0, c.width, 4'd0, c.height};
			1: w = {4'd0, c.win_left, 4'd0, c.win_top};
			2: w = {4'd0, c.win_width, 4'd0, c.win_height};
			3: w = {4'd0, c.dst_left, 4'd0, c.dst_top};
			4: w = {4'd0, c.dst_width, 4'd0, c.dst_height};
			5: w[`FSCTL_STREAM_NBR-1:0] = c.dst_bmp;
			default: w = '0;
		endcase
		return w;
	endfunction

	function automatic logic [31:0] port_value(input string name, output bit found);
		int idx;
		int off;
		string field;
		logic [31:0] v;
		found = 1'b1;
		v = '0;
		if (name == "fsync")
			v = fsync_out;
		else if (name == "out_ce")
			v = out_ce;
		else if (name == "intr")
			v = intr;
		else if (name == "out_w")
			v = out_width;
		else if (name == "out_h")
			v = out_height;
		else if (name == "motors")
			v = |motor_out;
		else if (name.len() == 6 && name.substr(0, 3) == "live") begin
			idx = name[4] - 8'd48;
			off = name[5] - 8'd48;
			if (idx >= 0 && idx < `FSCTL_STREAM_NBR && off >= 0 && off < 6)
				v = live_word(idx, off);
			else
				found = 1'b0;
		end else if (name.len() == 6 && name.substr(0, 4) == "rd_en") begin
			idx = name[5] - 8'd48;
			if (idx >= 0 && idx < `FSCTL_STREAM_NBR)
				v = rd_en_cnt[idx];
			else
				found = 1'b0;
		end else if (name.len() > 3 && name[0] == "m" && name[2] == "_") begin
			idx = name[1] - 8'd48;
			field = name.substr(3, name.len() - 1);
			if (idx < 0 || idx >= `FSCTL_MOTOR_NBR)
				found = 1'b0;
			else if (field == "xen")
				v = motor_out[idx].xen;
			else if (field == "xrst")
				v = motor_out[idx].xrst;
			else if (field == "dir")
				v = motor_out[idx].dir;
			else if (field == "speed")
				v = motor_out[idx].speed;
			else if (field == "step")
				v = motor_out[idx].step;
			else if (field == "start")
				v = start_cnt[idx];
			else if (field == "stop")
				v = stop_cnt[idx];
			else
				found = 1'b0;
		end else
			found = 1'b0;
		return v;
	endfunction

	// ------------------------------
	// golden file operations
	// ------------------------------
	task automatic host_write(input logic [31:0] a, input logic [31:0] d);
		@(posedge clk);
		wr_en <= 1'b1;
		wr_addr <= a[7:0];
		wr_data <= d;
		@(posedge clk);
		wr_en <= 1'b0;
		repeat (3) @(posedge clk);
	endtask

	// read data lands on the edge after the sampling edge
	task automatic host_read(input logic [31:0] a, input logic [31:0] exp);
		@(posedge clk);
		rd_en <= 1'b1;
		rd_addr <= a[7:0];
		@(posedge clk);
		rd_en <= 1'b0;
		@(posedge clk);
		@(negedge clk);
		check_value("o_rd_data", exp, rd_data);
	endtask

	// o_fsync is high for the one cycle after the third edge that sees the sync
	task automatic frame_pulse();
		@(posedge clk);
		fsync_in <= 1'b1;
		@(posedge clk);
		@(posedge clk);
		fsync_in <= 1'b0;
		@(negedge clk);
		check_value("o_fsync", 32'd0, fsync_out);
		check_value("o_out_ce", (frames > 0) ? 32'd1 : 32'd0, out_ce);
		@(posedge clk);
		@(negedge clk);
		check_value("o_fsync", 32'd1, fsync_out);
		check_value("o_out_ce", 32'd1, out_ce);
		@(posedge clk);
		@(negedge clk);
		check_value("o_fsync", 32'd0, fsync_out);
		frames++;
		@(posedge clk);
	endtask

	task automatic done_pulse(input int s);
		@(posedge clk);
		wr_done[s] <= 1'b1;
		@(posedge clk);
		wr_done[s] <= 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic set_motor_state(input int m, input logic v);
		@(posedge clk);
		motor_state[m] <= v;
		repeat (3) @(posedge clk);
	endtask

	initial begin
		int fd;
		int n;
		bit found;
		string line;
		string op;
		string name;
		logic [31:0] a;
		logic [31:0] d;
		logic [31:0] v;
		wr_en <= 1'b0;
		wr_addr <= '0;
		wr_data <= '0;
		rd_en <= 1'b0;
		rd_addr <= '0;
		fsync_in <= 1'b0;
		wr_done <= '0;
		buf_idx <= {2'd2, 2'd1};
		motor_state <= '0;
		void'($urandom(32'hd846_0408));
		fd = $fopen("fsctl_golden.txt", "r");
		if (fd == 0) begin
			$display("cannot open golden file fsctl_golden.txt");
			errors++;
		end else begin
			n = 0;
			while ($fgets(line, fd) != 0)
				n++;
			$fclose(fd);
			limit = n * 64;
			fd = $fopen("fsctl_golden.txt", "r");
			wait (resetn === 1'b1);
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line[0] == "#")
					continue;
				void'($sscanf(line, "%s", op));
				repeat ($urandom % 4) @(posedge clk);
				if (op == "W") begin
					void'($sscanf(line, "%s %h %h", op, a, d));
					host_write(a, d);
				end else if (op == "R") begin
					void'($sscanf(line, "%s %h %h", op, a, d));
					host_read(a, d);
				end else if (op == "F") begin
					frame_pulse();
				end else if (op == "D") begin
					void'($sscanf(line, "%s %h", op, a));
					done_pulse(a);
				end else if (op == "S") begin
					void'($sscanf(line, "%s %h %h", op, a, d));
					set_motor_state(a, d[0]);
				end else if (op == "C") begin
					void'($sscanf(line, "%s %s %h", op, name, d));
					@(negedge clk);
					v = port_value(name, found);
					if (found)
						check_value(name, d, v);
					else begin
						$display("golden file names an unknown port: %s", name);
						errors++;
						test_errors++;
					end
				end else if (op == "T") begin
					void'($sscanf(line, "%s %s", op, name));
					tests++;
					$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
					test_checks = 0;
					test_errors = 0;
				end else begin
					$display("golden file has an unknown operation: %s", op);
					errors++;
				end
			end
			$fclose(fd);
		end
		$display("total: %0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
